/* flist.f */
+incdir+.
branchPkg.sv
uopPkg.sv
bitCount.sv
operandStage.sv
intAlu.sv
branchResolve.sv
intExecCluster.sv
clkRstGen.sv
intExecTb.sv

/* Bender.yml */
package:
  name: int_exec_cluster

sources:
  - include_dirs:
      - .
    files:
      - branchPkg.sv
      - uopPkg.sv
      - bitCount.sv
      - operandStage.sv
      - intAlu.sv
      - branchResolve.sv
      - intExecCluster.sv
      - target: test
        files:
          - clkRstGen.sv
          - intExecTb.sv

/* intExecTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "intExec_macros.svh"

module intExecTb;

    localparam int numLanes = `NUM_LANES;
    // The tests take about 70 cycles.
    localparam int maxCycles = 200;

    logic clk;
    logic rst;
    uopPkg::IssueUop issue [numLanes];
    uopPkg::ResUop results [numLanes];
    branchPkg::BranchProv branch;

    uopPkg::IssueUop group [numLanes];
    branchPkg::SqN nextSqN = '0;
    int cycles = 0;

    clkRstGen clkGen (
        .clk(clk),
        .rst(rst)
    );

    intExecCluster uut (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .results(results),
        .branch(branch)
    );

    task automatic endWithFailure();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= maxCycles) begin
            $display("Timeout after %0d cycles, the tests did not finish.", cycles);
            endWithFailure();
        end
    end

    task automatic checkResult(uopPkg::ResUop got, uopPkg::ResUop exp, string name);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            endWithFailure();
        end
    endtask

    task automatic checkBranch(branchPkg::BranchProv got, branchPkg::BranchProv exp,
            string name);
        if (got.taken !== exp.taken || (exp.taken &&
                {got.sqN, got.dstPC, got.cause, got.retAct} !==
                {exp.sqN, exp.dstPC, exp.cause, exp.retAct})) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            endWithFailure();
        end
    endtask

    function automatic logic [31:0] opB(uopPkg::IssueUop u);
        return u.immB ? u.imm : u.rsB;
    endfunction

    function automatic logic [31:0] firstHalf(uopPkg::IssueUop u);
        return u.compressed ? u.pc : u.pc - 32'd2;
    endfunction

    function automatic logic isCond(uopPkg::IssueUop u);
        return u.fu == uopPkg::FU_BRANCH && u.opcode <= uopPkg::BR_BGEU;
    endfunction

    function automatic logic isIndirect(uopPkg::IssueUop u);
        return u.fu == uopPkg::FU_BRANCH &&
            u.opcode inside {uopPkg::BR_JALR, uopPkg::BR_JR, uopPkg::BR_RET};
    endfunction

    // True when x comes before y in program order.
    function automatic logic isOlder(branchPkg::SqN x, branchPkg::SqN y);
        branchPkg::SqN diff;
        diff = x - y;
        return diff[`SQN_BITS-1];
    endfunction

    function automatic logic condOutcome(uopPkg::IssueUop u);
        logic [31:0] b;
        b = opB(u);
        case (u.opcode)
            uopPkg::BR_BEQ: return u.rsA == b;
            uopPkg::BR_BNE: return u.rsA != b;
            uopPkg::BR_BLT: return $signed(u.rsA) < $signed(b);
            uopPkg::BR_BGE: return $signed(u.rsA) >= $signed(b);
            uopPkg::BR_BLTU: return u.rsA < b;
            uopPkg::BR_BGEU: return u.rsA >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] refValue(uopPkg::IssueUop u);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0] sh;
        logic [31:0] r;
        a = u.rsA;
        b = opB(u);
        sh = b[4:0];
        r = '0;
        if (u.fu == uopPkg::FU_INT) begin
            case (u.opcode)
                uopPkg::INT_ADD: r = a + b;
                uopPkg::INT_SUB: r = a - b;
                uopPkg::INT_XOR: r = a ^ b;
                uopPkg::INT_OR: r = a | b;
                uopPkg::INT_AND: r = a & b;
                uopPkg::INT_SLL: r = a << sh;
                uopPkg::INT_SRL: r = a >> sh;
                uopPkg::INT_SRA: r = 32'($signed(a) >>> sh);
                uopPkg::INT_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                uopPkg::INT_SLTU: r = (a < b) ? 32'd1 : 32'd0;
                uopPkg::INT_MIN: r = ($signed(a) < $signed(b)) ? a : b;
                uopPkg::INT_MINU: r = (a < b) ? a : b;
                uopPkg::INT_MAX: r = ($signed(a) > $signed(b)) ? a : b;
                uopPkg::INT_MAXU: r = (a > b) ? a : b;
                uopPkg::INT_LUI: r = b;
                uopPkg::INT_SH1ADD: r = a * 2 + b;
                uopPkg::INT_SH2ADD: r = a * 4 + b;
                uopPkg::INT_SH3ADD: r = a * 8 + b;
                uopPkg::INT_ANDN: r = a & ~b;
                uopPkg::INT_ORN: r = a | ~b;
                uopPkg::INT_XNOR: r = ~(a ^ b);
                uopPkg::INT_SE_B: r = 32'($signed(a[7:0]));
                uopPkg::INT_SE_H: r = 32'($signed(a[15:0]));
                uopPkg::INT_ZE_H: r = 32'(a[15:0]);
                default: r = '0;
            endcase
        end else if (u.fu == uopPkg::FU_BITMANIP) begin
            case (u.opcode)
                uopPkg::BM_CLZ: begin
                    for (int i = 31; i >= 0 && !a[i]; i--) begin
                        r++;
                    end
                end
                uopPkg::BM_CTZ: begin
                    for (int i = 0; i < 32 && !a[i]; i++) begin
                        r++;
                    end
                end
                uopPkg::BM_CPOP: begin
                    for (int i = 0; i < 32; i++) begin
                        r = r + 32'(a[i]);
                    end
                end
                uopPkg::BM_ROL: r = (a << sh) | (a >> (32 - sh));
                uopPkg::BM_ROR: r = (a >> sh) | (a << (32 - sh));
                uopPkg::BM_ORC_B: begin
                    for (int k = 0; k < 4; k++) begin
                        r[8*k +: 8] = (a[8*k +: 8] != 8'h00) ? 8'hFF : 8'h00;
                    end
                end
                uopPkg::BM_REV8: begin
                    for (int k = 0; k < 4; k++) begin
                        r[8*k +: 8] = a[8*(3-k) +: 8];
                    end
                end
                uopPkg::BM_BCLR: r = a & ~(32'd1 << sh);
                uopPkg::BM_BEXT: r = (a >> sh) & 32'd1;
                uopPkg::BM_BINV: r = a ^ (32'd1 << sh);
                uopPkg::BM_BSET: r = a | (32'd1 << sh);
                default: r = '0;
            endcase
        end else if (u.opcode == uopPkg::BR_AUIPC) begin
            r = firstHalf(u) + u.imm;
        end else if (u.opcode inside {uopPkg::BR_JAL, uopPkg::BR_JALR, uopPkg::BR_JR}) begin
            r = u.pc + 32'd2;
        end
        return r;
    endfunction

    function automatic uopPkg::ResUop expectResult(uopPkg::IssueUop u);
        uopPkg::ResUop r;
        r.valid = u.valid;
        r.result = refValue(u);
        r.tagDst = u.tagDst;
        r.sqN = u.sqN;
        if (isCond(u)) begin
            r.flags = condOutcome(u) ? uopPkg::FLAGS_PRED_TAKEN : uopPkg::FLAGS_PRED_NTAKEN;
        end else if (isIndirect(u)) begin
            r.flags = uopPkg::FLAGS_BRANCH;
        end else begin
            r.flags = uopPkg::FLAGS_NONE;
        end
        return r;
    endfunction

    function automatic branchPkg::BranchProv refRedirect(uopPkg::IssueUop u);
        branchPkg::BranchProv p;
        logic [31:0] target;
        logic [31:0] predicted;
        p = '0;
        p.sqN = u.sqN;
        predicted = opB(u);
        if (u.valid && isCond(u) && condOutcome(u) != u.bpi.taken) begin
            p.taken = 1'b1;
            if (condOutcome(u)) begin
                p.dstPC = firstHalf(u) + 32'($signed(u.imm[12:0]));
                p.cause = branchPkg::FLUSH_BRANCH_TK;
            end else begin
                p.dstPC = u.pc + 32'd2;
                p.cause = branchPkg::FLUSH_BRANCH_NT;
            end
        end else if (u.valid && isIndirect(u)) begin
            target = (u.opcode == uopPkg::BR_RET) ? u.rsA : u.rsA + 32'($signed(u.imm[11:0]));
            target[0] = 1'b0;
            p.dstPC = target;
            p.taken = (target[31:1] != predicted[31:1]) || !u.bpi.taken;
            p.cause = branchPkg::FLUSH_IBRANCH;
            if (u.opcode == uopPkg::BR_RET) begin
                p.cause = branchPkg::FLUSH_RETURN;
                p.retAct = branchPkg::RET_POP;
            end else if (u.opcode == uopPkg::BR_JALR) begin
                p.retAct = branchPkg::RET_PUSH;
            end
        end
        return p;
    endfunction

    // The front end gets the oldest redirect of the group.
    function automatic branchPkg::BranchProv expectBranch();
        branchPkg::BranchProv best;
        branchPkg::BranchProv cand;
        best = '0;
        for (int i = 0; i < numLanes; i++) begin
            cand = refRedirect(group[i]);
            if (cand.taken && (!best.taken || isOlder(cand.sqN, best.sqN))) begin
                best = cand;
            end
        end
        return best;
    endfunction

    task automatic setSlot(int slot, uopPkg::FuncUnit fu, logic [4:0] op, logic [31:0] a,
            logic [31:0] b, logic [31:0] imm, logic immB);
        uopPkg::IssueUop u;
        u = '0;
        u.valid = 1'b1;
        u.fu = fu;
        u.opcode = op;
        u.rsA = a;
        u.rsB = b;
        u.imm = imm;
        u.immB = immB;
        u.pc = $urandom & 32'hFFFF_FFFE;
        u.tagDst = uopPkg::Tag'($urandom);
        u.sqN = nextSqN;
        nextSqN = nextSqN + 1'b1;
        group[slot] = u;
    endtask

    task automatic setBranch(int slot, logic [4:0] op, logic [31:0] a, logic [31:0] b,
            logic [31:0] imm, logic predTaken, logic compressed);
        setSlot(slot, uopPkg::FU_BRANCH, op, a, b, imm, 1'b0);
        group[slot].bpi.taken = predTaken;
        group[slot].compressed = compressed;
    endtask

    task automatic driveGroup();
        for (int i = 0; i < numLanes; i++) begin
            issue[i] <= group[i];
        end
    endtask

    task automatic driveIdle();
        for (int i = 0; i < numLanes; i++) begin
            issue[i] <= '0;
        end
    endtask

    task automatic runGroup();
        uopPkg::ResUop exp [numLanes];
        branchPkg::BranchProv expBr;
        for (int i = 0; i < numLanes; i++) begin
            exp[i] = expectResult(group[i]);
        end
        expBr = expectBranch();
        @(posedge clk);
        driveGroup();
        @(posedge clk);
        driveIdle();
        @(posedge clk);
        @(negedge clk);
        for (int i = 0; i < numLanes; i++) begin
            checkResult(results[i], exp[i], $sformatf("results[%0d]", i));
        end
        checkBranch(branch, expBr, "branch");
    endtask

    task automatic testReset();
        uopPkg::ResUop idleRes;
        branchPkg::BranchProv noBranch;
        idleRes = '0;
        noBranch = '0;
        @(negedge clk);
        // Once while reset is high and once right after it drops.
        for (int n = 0; n < 2; n++) begin
            for (int i = 0; i < numLanes; i++) begin
                checkResult(results[i], idleRes, $sformatf("results[%0d]", i));
            end
            checkBranch(branch, noBranch, "branch");
            wait (!rst);
            @(negedge clk);
        end
    endtask

    task automatic testInteger();
        for (int op = 0; op <= int'(uopPkg::INT_ZE_H); op += numLanes) begin
            for (int s = 0; s < numLanes; s++) begin
                setSlot(s, uopPkg::FU_INT, 5'(op + s), $urandom, $urandom, $urandom,
                    1'($urandom));
            end
            runGroup();
        end
    endtask

    task automatic testBitManip();
        logic [31:0] edges [4];
        edges = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_0001, 32'h8000_0000};
        foreach (edges[e]) begin
            setSlot(0, uopPkg::FU_BITMANIP, uopPkg::BM_CLZ, edges[e], 32'd0, 32'd0, 1'b0);
            setSlot(1, uopPkg::FU_BITMANIP, uopPkg::BM_CTZ, edges[e], 32'd0, 32'd0, 1'b0);
            setSlot(2, uopPkg::FU_BITMANIP, uopPkg::BM_CPOP, edges[e], 32'd0, 32'd0, 1'b0);
            runGroup();
        end
        // The opcodes from rol through bset get random operands.
        for (int k = 0; k < 9; k += numLanes) begin
            for (int s = 0; s < numLanes; s++) begin
                setSlot(s, uopPkg::FU_BITMANIP, 5'(3 + (k + s) % 8), $urandom, $urandom,
                    $urandom, 1'($urandom));
            end
            runGroup();
        end
    endtask

    task automatic testBranches();
        setBranch(0, uopPkg::BR_BEQ, 32'h1234, 32'h1234, 32'h0000_0100, 1'b1, 1'b0);
        setBranch(1, uopPkg::BR_BLTU, 32'h5, 32'h3, 32'h0000_0040, 1'b0, 1'b0);
        setBranch(2, uopPkg::BR_AUIPC, $urandom, $urandom, 32'h0001_2000, 1'b0, 1'b0);
        runGroup();
        setBranch(0, uopPkg::BR_BLT, 32'hFFFF_FFFF, 32'h1, 32'h0000_1FF0, 1'b0, 1'b0);
        setBranch(1, uopPkg::BR_JAL, $urandom, $urandom, $urandom, 1'b1, 1'b1);
        setBranch(2, uopPkg::BR_AUIPC, $urandom, $urandom, 32'hFFFF_F000, 1'b0, 1'b1);
        runGroup();
        setBranch(0, uopPkg::BR_BGE, 32'hFFFF_FFFB, 32'h3, 32'h0000_0080, 1'b1, 1'b0);
        setBranch(1, uopPkg::BR_JAL, $urandom, $urandom, $urandom, 1'b1, 1'b0);
        setBranch(2, uopPkg::BR_BGEU, 32'hFFFF_FFFB, 32'h3, 32'h0000_0020, 1'b1, 1'b1);
        runGroup();
    endtask

    task automatic testIndirect();
        // The ret is older than the jalr, so a false redirect from it would win.
        setBranch(0, uopPkg::BR_RET, 32'h0000_4567, 32'h0000_4566, 32'h0, 1'b1, 1'b0);
        setBranch(1, uopPkg::BR_JALR, 32'h0000_2000, 32'h0000_3000, 32'h0000_0011, 1'b1, 1'b0);
        setSlot(2, uopPkg::FU_INT, uopPkg::INT_ADD, $urandom, $urandom, $urandom, 1'b0);
        runGroup();
        setBranch(0, uopPkg::BR_JR, 32'h0000_8000, 32'h0000_7FF8, 32'h0000_0FF8, 1'b0, 1'b0);
        setSlot(1, uopPkg::FU_INT, uopPkg::INT_SUB, $urandom, $urandom, $urandom, 1'b0);
        setSlot(2, uopPkg::FU_INT, uopPkg::INT_XOR, $urandom, $urandom, $urandom, 1'b1);
        runGroup();
    endtask

    task automatic testOldestAndSquash();
        uopPkg::ResUop expA [numLanes];
        uopPkg::ResUop expB;
        branchPkg::BranchProv expBr;
        branchPkg::BranchProv noBranch;
        noBranch = '0;
        // Slot 0 is younger than slot 1 because the sequence numbers wrap.
        setBranch(0, uopPkg::BR_BEQ, 32'h7, 32'h7, 32'h0000_0040, 1'b0, 1'b0);
        setBranch(1, uopPkg::BR_BNE, 32'h9, 32'h9, 32'h0000_0080, 1'b1, 1'b0);
        setSlot(2, uopPkg::FU_INT, uopPkg::INT_ADD, $urandom, $urandom, $urandom, 1'b0);
        group[0].sqN = 7'd2;
        group[1].sqN = 7'd126;
        group[2].sqN = 7'd127;
        for (int i = 0; i < numLanes; i++) begin
            expA[i] = expectResult(group[i]);
        end
        expBr = expectBranch();
        @(posedge clk);
        driveGroup();
        for (int s = 0; s < numLanes; s++) begin
            setSlot(s, uopPkg::FU_INT, uopPkg::INT_OR, $urandom, $urandom, $urandom, 1'b0);
        end
        group[0].sqN = 7'd0;
        group[1].sqN = 7'd125;
        group[2].sqN = 7'd126;
        @(posedge clk);
        driveGroup();
        @(posedge clk);
        driveIdle();
        @(negedge clk);
        for (int i = 0; i < numLanes; i++) begin
            checkResult(results[i], expA[i], $sformatf("results[%0d]", i));
        end
        checkBranch(branch, expBr, "branch");
        @(posedge clk);
        @(negedge clk);
        for (int i = 0; i < numLanes; i++) begin
            expB = expectResult(group[i]);
            expB.valid = !isOlder(expBr.sqN, group[i].sqN);
            checkResult(results[i], expB, $sformatf("results[%0d]", i));
        end
        checkBranch(branch, noBranch, "branch");
    endtask

    initial begin
        void'($urandom(16));
        for (int i = 0; i < numLanes; i++) begin
            issue[i] = '0;
        end
        testReset();
        testInteger();
        testBitManip();
        testBranches();
        testIndirect();
        testOldestAndSquash();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* clkRstGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clkRstGen #(
    parameter int halfPeriod = 2,
    parameter int resetCycles = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

    // Reset is released on a rising edge, like every other DUT input.
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* intExecCluster.sv */
`timescale 1ns/10ps
`default_nettype none

`include "intExec_macros.svh"

module intExecCluster #(
    parameter int numLanes = `NUM_LANES
) (
    input wire clk,
    input wire rst,
    input wire uopPkg::IssueUop issue [numLanes],
    output uopPkg::ResUop results [numLanes],
    output branchPkg::BranchProv branch
);

    uopPkg::ExUop exUops [numLanes];
    uopPkg::ResUop laneResults [numLanes];
    branchPkg::BranchProv laneBranch [numLanes];

    operandStage #(
        .numLanes(numLanes)
    ) opStage (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .exUops(exUops)
    );

    // Every lane sees the registered redirect so it can drop younger work.
    for (genvar i = 0; i < numLanes; i++) begin : gLane
        intAlu alu (
            .clk(clk),
            .rst(rst),
            .uop(exUops[i]),
            .branchIn(branch),
            .branchOut(laneBranch[i]),
            .result(laneResults[i])
        );
    end

    branchResolve #(
        .numLanes(numLanes)
    ) resolver (
        .clk(clk),
        .rst(rst),
        .laneBranch(laneBranch),
        .branch(branch)
    );

    assign results = laneResults;

endmodule

`default_nettype wire

/* branchResolve.sv */
`timescale 1ns/10ps
`default_nettype none

`include "intExec_macros.svh"

module branchResolve #(
    parameter int numLanes = `NUM_LANES
) (
    input wire clk,
    input wire rst,
    input wire branchPkg::BranchProv laneBranch [numLanes],
    output branchPkg::BranchProv branch
);

    branchPkg::BranchProv nextBranch;

    // The current provision joins the comparison, but it only survives
    // when some lane raises a new redirect this cycle.
    always_comb begin
        branchPkg::BranchProv oldest;
        branchPkg::SqN ageDiff;
        logic anyLane;

        oldest = branch;
        anyLane = 1'b0;
        for (int i = 0; i < numLanes; i++) begin
            ageDiff = laneBranch[i].sqN - oldest.sqN;
            if (laneBranch[i].taken) begin
                anyLane = 1'b1;
                if (!oldest.taken || $signed(ageDiff) < 0) begin
                    oldest = laneBranch[i];
                end
            end
        end

        nextBranch = oldest;
        if (!anyLane) begin
            nextBranch.taken = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        branch.sqN <= nextBranch.sqN;
        branch.dstPC <= nextBranch.dstPC;
        branch.cause <= nextBranch.cause;
        branch.retAct <= nextBranch.retAct;
        if (rst) begin
            branch.taken <= 1'b0;
        end else begin
            branch.taken <= nextBranch.taken;
        end
    end

endmodule

`default_nettype wire

/* intAlu.sv */
`timescale 1ns/10ps
`default_nettype none

module intAlu (
    input wire clk,
    input wire rst,
    input wire uopPkg::ExUop uop,
    input wire branchPkg::BranchProv branchIn,
    output branchPkg::BranchProv branchOut,
    output uopPkg::ResUop result
);

    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] imm;
    logic [31:0] srcARev;
    logic [31:0] cntIn;
    logic [5:0] lzCnt;
    logic [5:0] popCnt;
    logic lessThan;
    logic lessThanU;
    logic [31:0] nextInstrPC;
    logic [31:0] firstHalfwPC;
    logic [63:0] rolWide;
    logic [63:0] rorWide;
    logic [31:0] bitMask;
    logic [31:0] resC;
    branchPkg::SqN ageDiff;
    logic execute;
    logic isCond;
    logic isIndirect;
    logic condTaken;
    logic [31:0] indDst;
    logic indCorrect;
    uopPkg::ResFlags flags;

    assign srcA = uop.srcA;
    assign srcB = uop.srcB;
    assign imm = uop.imm;

    // Anything younger than a taken redirect is on the wrong path.
    assign ageDiff = uop.sqN - branchIn.sqN;
    assign execute = uop.valid && (!branchIn.taken || $signed(ageDiff) <= 0);

    // Trailing zeros are the leading zeros of the reversed word.
    assign srcARev = {<<{srcA}};
    assign cntIn = (uop.opcode == uopPkg::BM_CLZ) ? srcA : srcARev;

    bitCount counter (
        .in(cntIn),
        .lzCnt(lzCnt),
        .popCnt(popCnt)
    );

    assign lessThan = $signed(srcA) < $signed(srcB);
    assign lessThanU = srcA < srcB;

    assign nextInstrPC = uop.pc + 32'd2;
    assign firstHalfwPC = uop.compressed ? uop.pc : uop.pc - 32'd2;

    assign rolWide = {srcA, srcA} << srcB[4:0];
    assign rorWide = {srcA, srcA} >> srcB[4:0];
    assign bitMask = 32'd1 << srcB[4:0];

    always_comb begin
        resC = '0;
        case (uop.fu)
            uopPkg::FU_INT: begin
                case (uop.opcode)
                    uopPkg::INT_ADD: resC = srcA + srcB;
                    uopPkg::INT_SUB: resC = srcA - srcB;
                    uopPkg::INT_XOR: resC = srcA ^ srcB;
                    uopPkg::INT_OR: resC = srcA | srcB;
                    uopPkg::INT_AND: resC = srcA & srcB;
                    uopPkg::INT_SLL: resC = srcA << srcB[4:0];
                    uopPkg::INT_SRL: resC = srcA >> srcB[4:0];
                    uopPkg::INT_SRA: resC = $signed(srcA) >>> srcB[4:0];
                    uopPkg::INT_SLT: resC = {31'b0, lessThan};
                    uopPkg::INT_SLTU: resC = {31'b0, lessThanU};
                    uopPkg::INT_MIN: resC = lessThan ? srcA : srcB;
                    uopPkg::INT_MINU: resC = lessThanU ? srcA : srcB;
                    uopPkg::INT_MAX: resC = lessThan ? srcB : srcA;
                    uopPkg::INT_MAXU: resC = lessThanU ? srcB : srcA;
                    uopPkg::INT_LUI: resC = srcB;
                    uopPkg::INT_SH1ADD: resC = srcB + (srcA << 1);
                    uopPkg::INT_SH2ADD: resC = srcB + (srcA << 2);
                    uopPkg::INT_SH3ADD: resC = srcB + (srcA << 3);
                    uopPkg::INT_ANDN: resC = srcA & ~srcB;
                    uopPkg::INT_ORN: resC = srcA | ~srcB;
                    uopPkg::INT_XNOR: resC = srcA ^ ~srcB;
                    uopPkg::INT_SE_B: resC = {{24{srcA[7]}}, srcA[7:0]};
                    uopPkg::INT_SE_H: resC = {{16{srcA[15]}}, srcA[15:0]};
                    uopPkg::INT_ZE_H: resC = {16'b0, srcA[15:0]};
                    default: ;
                endcase
            end
            uopPkg::FU_BRANCH: begin
                case (uop.opcode)
                    uopPkg::BR_AUIPC: resC = firstHalfwPC + imm;
                    uopPkg::BR_JAL,
                    uopPkg::BR_JALR,
                    uopPkg::BR_JR: resC = nextInstrPC;
                    default: ;
                endcase
            end
            uopPkg::FU_BITMANIP: begin
                case (uop.opcode)
                    uopPkg::BM_CLZ,
                    uopPkg::BM_CTZ: resC = {26'b0, lzCnt};
                    uopPkg::BM_CPOP: resC = {26'b0, popCnt};
                    uopPkg::BM_ROL: resC = rolWide[63:32];
                    uopPkg::BM_ROR: resC = rorWide[31:0];
                    uopPkg::BM_ORC_B: resC = {{8{|srcA[31:24]}}, {8{|srcA[23:16]}},
                                              {8{|srcA[15:8]}}, {8{|srcA[7:0]}}};
                    uopPkg::BM_REV8: resC = {srcA[7:0], srcA[15:8], srcA[23:16], srcA[31:24]};
                    uopPkg::BM_BCLR: resC = srcA & ~bitMask;
                    uopPkg::BM_BEXT: resC = {31'b0, srcA[srcB[4:0]]};
                    uopPkg::BM_BINV: resC = srcA ^ bitMask;
                    uopPkg::BM_BSET: resC = srcA | bitMask;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign isCond = (uop.fu == uopPkg::FU_BRANCH) && (uop.opcode inside {
        uopPkg::BR_BEQ, uopPkg::BR_BNE, uopPkg::BR_BLT,
        uopPkg::BR_BGE, uopPkg::BR_BLTU, uopPkg::BR_BGEU});
    assign isIndirect = (uop.fu == uopPkg::FU_BRANCH) && (uop.opcode inside {
        uopPkg::BR_JALR, uopPkg::BR_JR, uopPkg::BR_RET});

    always_comb begin
        case (uop.opcode)
            uopPkg::BR_BEQ: condTaken = (srcA == srcB);
            uopPkg::BR_BNE: condTaken = (srcA != srcB);
            uopPkg::BR_BLT: condTaken = lessThan;
            uopPkg::BR_BGE: condTaken = !lessThan;
            uopPkg::BR_BLTU: condTaken = lessThanU;
            uopPkg::BR_BGEU: condTaken = !lessThanU;
            default: condTaken = 1'b0;
        endcase
    end

    // srcB holds the target that the front end predicted.
    always_comb begin
        if (uop.opcode == uopPkg::BR_RET) begin
            indDst = {srcA[31:1], 1'b0};
        end else begin
            indDst = srcA + {{20{imm[11]}}, imm[11:0]};
            indDst[0] = 1'b0;
        end
        indCorrect = (indDst[31:1] == srcB[31:1]);
    end

    always_comb begin
        branchOut = '0;
        branchOut.sqN = uop.sqN;
        if (execute && isCond && condTaken != uop.bpi.taken) begin
            branchOut.taken = 1'b1;
            if (condTaken) begin
                branchOut.dstPC = firstHalfwPC + {{19{imm[12]}}, imm[12:0]};
                branchOut.cause = branchPkg::FLUSH_BRANCH_TK;
            end else begin
                branchOut.dstPC = nextInstrPC;
                branchOut.cause = branchPkg::FLUSH_BRANCH_NT;
            end
        end else if (execute && isIndirect && (!indCorrect || !uop.bpi.taken)) begin
            branchOut.taken = 1'b1;
            branchOut.dstPC = indDst;
            if (uop.opcode == uopPkg::BR_RET) begin
                branchOut.cause = branchPkg::FLUSH_RETURN;
                branchOut.retAct = branchPkg::RET_POP;
            end else begin
                branchOut.cause = branchPkg::FLUSH_IBRANCH;
                if (uop.opcode == uopPkg::BR_JALR) begin
                    branchOut.retAct = branchPkg::RET_PUSH;
                end
            end
        end
    end

    always_comb begin
        if (isCond) begin
            flags = condTaken ? uopPkg::FLAGS_PRED_TAKEN : uopPkg::FLAGS_PRED_NTAKEN;
        end else if (isIndirect) begin
            flags = uopPkg::FLAGS_BRANCH;
        end else begin
            flags = uopPkg::FLAGS_NONE;
        end
    end

    always_ff @(posedge clk) begin
        result.result <= resC;
        result.tagDst <= uop.tagDst;
        result.sqN <= uop.sqN;
        result.flags <= flags;
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= execute;
        end
    end

endmodule

`default_nettype wire

/* operandStage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "intExec_macros.svh"

module operandStage #(
    parameter int numLanes = `NUM_LANES
) (
    input wire clk,
    input wire rst,
    input wire uopPkg::IssueUop issue [numLanes],
    output uopPkg::ExUop exUops [numLanes]
);

    always_ff @(posedge clk) begin
        for (int i = 0; i < numLanes; i++) begin
            exUops[i].fu <= issue[i].fu;
            exUops[i].opcode <= issue[i].opcode;
            exUops[i].srcA <= issue[i].rsA;
            // Operand B is either the register value or the immediate.
            exUops[i].srcB <= issue[i].immB ? issue[i].imm : issue[i].rsB;
            exUops[i].imm <= issue[i].imm;
            exUops[i].pc <= issue[i].pc;
            exUops[i].compressed <= issue[i].compressed;
            exUops[i].tagDst <= issue[i].tagDst;
            exUops[i].sqN <= issue[i].sqN;
            exUops[i].bpi <= issue[i].bpi;

            if (rst) begin
                exUops[i].valid <= 1'b0;
            end else begin
                exUops[i].valid <= issue[i].valid;
            end
        end
    end

endmodule

`default_nettype wire

/* bitCount.sv */
`timescale 1ns/10ps
`default_nettype none

module bitCount (
    input wire [31:0] in,
    output logic [5:0] lzCnt,
    output logic [5:0] popCnt
);

    logic [3:0] byteCnt [4];
    logic [4:0] halfCnt [2];

    // The highest set bit is seen last and wins.
    always_comb begin
        lzCnt = 6'd32;
        for (int i = 0; i < 32; i++) begin
            if (in[i]) begin
                lzCnt = 6'(31 - i);
            end
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            byteCnt[b] = '0;
            for (int i = 0; i < 8; i++) begin
                byteCnt[b] = byteCnt[b] + 4'(in[8*b + i]);
            end
        end
        halfCnt[0] = 5'(byteCnt[0]) + 5'(byteCnt[1]);
        halfCnt[1] = 5'(byteCnt[2]) + 5'(byteCnt[3]);
        popCnt = 6'(halfCnt[0]) + 6'(halfCnt[1]);
    end

endmodule

`default_nettype wire

/* uopPkg.sv */
`default_nettype none

`include "intExec_macros.svh"

package uopPkg;

    typedef logic [`TAG_BITS-1:0] Tag;

    typedef enum logic [1:0] {
        FU_INT,
        FU_BRANCH,
        FU_BITMANIP
    } FuncUnit;

    // The opcode is decoded per function unit.
    typedef logic [4:0] Opcode;

    typedef enum logic [4:0] {
        INT_ADD, INT_SUB, INT_XOR, INT_OR, INT_AND, INT_SLL, INT_SRL, INT_SRA,
        INT_SLT, INT_SLTU, INT_MIN, INT_MINU, INT_MAX, INT_MAXU, INT_LUI,
        INT_SH1ADD, INT_SH2ADD, INT_SH3ADD, INT_ANDN, INT_ORN, INT_XNOR,
        INT_SE_B, INT_SE_H, INT_ZE_H
    } IntOp;

    typedef enum logic [4:0] {
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU,
        BR_JAL, BR_AUIPC, BR_JALR, BR_JR, BR_RET
    } BranchOp;

    typedef enum logic [4:0] {
        BM_CLZ, BM_CTZ, BM_CPOP, BM_ROL, BM_ROR, BM_ORC_B, BM_REV8,
        BM_BCLR, BM_BEXT, BM_BINV, BM_BSET
    } BitOp;

    typedef enum logic [1:0] {
        FLAGS_NONE,
        FLAGS_BRANCH,
        FLAGS_PRED_TAKEN,
        FLAGS_PRED_NTAKEN
    } ResFlags;

    typedef struct packed {
        logic valid;
        FuncUnit fu;
        Opcode opcode;
        logic [31:0] rsA;
        logic [31:0] rsB;
        logic [31:0] imm;
        logic immB;
        logic [31:0] pc;
        logic compressed;
        Tag tagDst;
        branchPkg::SqN sqN;
        branchPkg::BranchPredInfo bpi;
    } IssueUop;

    typedef struct packed {
        logic valid;
        FuncUnit fu;
        Opcode opcode;
        logic [31:0] srcA;
        logic [31:0] srcB;
        logic [31:0] imm;
        logic [31:0] pc;
        logic compressed;
        Tag tagDst;
        branchPkg::SqN sqN;
        branchPkg::BranchPredInfo bpi;
    } ExUop;

    typedef struct packed {
        logic valid;
        logic [31:0] result;
        Tag tagDst;
        branchPkg::SqN sqN;
        ResFlags flags;
    } ResUop;

endpackage

`default_nettype wire

/* branchPkg.sv */
`default_nettype none

`include "intExec_macros.svh"

package branchPkg;

    typedef logic [`SQN_BITS-1:0] SqN;

    typedef struct packed {
        logic taken;
    } BranchPredInfo;

    typedef enum logic [1:0] {
        FLUSH_BRANCH_TK,
        FLUSH_BRANCH_NT,
        FLUSH_IBRANCH,
        FLUSH_RETURN
    } FlushCause;

    typedef enum logic [1:0] {
        RET_NONE,
        RET_PUSH,
        RET_POP
    } RetAct;

    // A redirect to the front end. Only taken carries meaning when it is clear.
    typedef struct packed {
        logic taken;
        SqN sqN;
        logic [31:0] dstPC;
        FlushCause cause;
        RetAct retAct;
    } BranchProv;

endpackage

`default_nettype wire

/* intExec_macros.svh */
`ifndef INT_EXEC_MACROS_SVH
`define INT_EXEC_MACROS_SVH

// Issue slots per group, and integer lanes.
`define NUM_LANES 3

// Program-order sequence number. It wraps, so age is a signed difference.
`define SQN_BITS 7

// Destination tag. A set top bit means there is no destination register.
`define TAG_BITS 7

`endif
